/* hdl/nf_hazard_pkg.sv */
package nf_hazard_pkg;

    // register file is x0..x31
    localparam int RF_AW = 5;                   // register address width

    // branch kind decoded in id stage
    typedef enum logic [3 : 0] {
        B_NONE    = 4'b0000,                    // not a branch or jump
        B_EQ_NEQ  = 4'b0001,                    // beq, bne
        B_GE_LT   = 4'b0010,                    // bge, blt
        B_GEU_LTU = 4'b0011,                    // bgeu, bltu
        B_JAL     = 4'b0100,                    // jump and link
        B_JALR    = 4'b0101                     // jump and link register
    } branch_t;

    // where an operand is taken from
    // mem stage result is newer than wb, so it wins when both match
    typedef enum logic [1 : 0] {
        FWD_NONE  = 2'b00,                      // register file read data
        FWD_MEM   = 2'b01,                      // result sitting in mem stage
        FWD_WB    = 2'b10                       // result sitting in wb stage
    } fwd_sel_t;

endpackage : nf_hazard_pkg

/* hdl/nf_hz_stall_unit.sv */
`timescale 1ns/1ns

module nf_hz_stall_unit
(
    // pipeline status
    input   logic   [0 : 0]                     we_rf_imem,     // rf write enable, mem stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_iexe,      // rf write address, exe stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_imem,      // rf write address, mem stage
    input   logic   [0 : 0]                     we_rf_iexe,     // rf write enable, exe stage
    input   logic   [0 : 0]                     rf_src_iexe,    // load result in exe stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra1_id,        // read address 1, id stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra2_id,        // read address 2, id stage
    input   nf_hazard_pkg::branch_t             branch_type,    // branch kind in id
    input   logic   [0 : 0]                     lsu_busy,       // lsu waiting on data memory
    input   logic   [0 : 0]                     lsu_err,        // lsu access fault
    input   logic   [0 : 0]                     req_ack_i,      // instruction fetch ack
    input   logic   [0 : 0]                     rf_src_imem,    // load result in mem stage
    // per stage control
    output  logic   [0 : 0]                     stall_if,       // hold fetch
    output  logic   [0 : 0]                     stall_id,       // hold decode
    output  logic   [0 : 0]                     stall_iexe,     // hold execute
    output  logic   [0 : 0]                     stall_imem,     // hold memory
    output  logic   [0 : 0]                     stall_iwb,      // hold write back
    output  logic   [0 : 0]                     flush_id,       // bubble into decode
    output  logic   [0 : 0]                     flush_iexe,     // bubble into execute
    output  logic   [0 : 0]                     flush_imem,     // bubble into memory
    output  logic   [0 : 0]                     flush_iwb       // bubble into write back
);

    logic   [0 : 0]     addr_hit;               // id operand matches exe or mem writer
    logic   [0 : 0]     load_use;               // operand still being loaded
    logic   [0 : 0]     br_src_hit;             // branch operand written by exe
    logic   [0 : 0]     br_nz;                  // branch reads a real register
    logic   [0 : 0]     branch_hz;              // comparator needs exe result
    logic   [0 : 0]     instr_wait;             // fetch not acknowledged
    logic   [0 : 0]     mem_busy;               // whole pipe frozen
    logic   [0 : 0]     front_hold;             // any reason to hold if and id

    // x0 deliberately not excluded here, a load to x0 still stalls
    assign addr_hit   = ( ra1_id == wa3_iexe ) || ( ra2_id == wa3_iexe ) ||
                        ( ra1_id == wa3_imem ) || ( ra2_id == wa3_imem );
    assign load_use   = addr_hit &&
                        ( we_rf_iexe || we_rf_imem ) &&     // somebody writes back
                        ( rf_src_iexe || rf_src_imem );     // and it is load data

    // comparator sits in id, so even an alu result in exe is too late
    assign br_src_hit = ( wa3_iexe == ra1_id ) || ( wa3_iexe == ra2_id );
    assign br_nz      = ( | ra1_id ) || ( | ra2_id );
    assign branch_hz  = ( branch_type != nf_hazard_pkg::B_NONE ) &&
                        we_rf_iexe &&
                        br_src_hit &&
                        br_nz;

    assign instr_wait = ~ req_ack_i;            // no instruction this cycle
    assign mem_busy   = lsu_busy;               // back pressure from data memory

    assign front_hold = load_use || branch_hz || instr_wait || mem_busy;

    assign stall_if   = front_hold;             // keep pc
    assign stall_id   = front_hold;             // keep decoded instruction
    assign stall_iexe = mem_busy;               // back end only stops on lsu
    assign stall_imem = mem_busy;
    assign stall_iwb  = mem_busy;

    // exe gets a bubble whenever the front end holds for a hazard
    assign flush_iexe = lsu_err || load_use || branch_hz || instr_wait;
    assign flush_id   = lsu_err;                // fault kills everything in flight
    assign flush_imem = lsu_err;
    assign flush_iwb  = lsu_err;

endmodule : nf_hz_stall_unit

/* hdl/nf_hz_bypass_unit.sv */
`timescale 1ns/1ns

module nf_hz_bypass_unit
(
    // operand addresses
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra1_iexe,      // read address 1, exe stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra2_iexe,      // read address 2, exe stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra1_id,        // read address 1, id stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra2_id,        // read address 2, id stage
    // writers further down the pipe
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_imem,      // write address, mem stage
    input   logic   [0 : 0]                     we_rf_imem,     // write enable, mem stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_iwb,       // write address, wb stage
    input   logic   [0 : 0]                     we_rf_iwb,      // write enable, wb stage
    // operand source selects
    output  nf_hazard_pkg::fwd_sel_t            rd1_fwd_iexe,   // exe operand 1 source
    output  nf_hazard_pkg::fwd_sel_t            rd2_fwd_iexe,   // exe operand 2 source
    output  nf_hazard_pkg::fwd_sel_t            cmp1_fwd_id,    // id comparator input 1 source
    output  nf_hazard_pkg::fwd_sel_t            cmp2_fwd_id     // id comparator input 2 source
);

    // true when a stage will write ra with a real value
    // x0 is hardwired so writes to it are never forwarded
    function automatic logic writer_hit(
        input   logic   [nf_hazard_pkg::RF_AW-1 : 0]    ra,     // operand address
        input   logic   [nf_hazard_pkg::RF_AW-1 : 0]    wa,     // writer address
        input   logic   [0 : 0]                         we      // writer enable
    );
        writer_hit = we && ( | wa ) && ( wa == ra );
    endfunction : writer_hit

    // newest producer first
    function automatic nf_hazard_pkg::fwd_sel_t pick_src(
        input   logic   [0 : 0]     mem_hit,    // mem stage writes the operand
        input   logic   [0 : 0]     wb_hit      // wb stage writes the operand
    );
        if (mem_hit) begin
            pick_src = nf_hazard_pkg::FWD_MEM;      // younger result wins
        end else if (wb_hit) begin
            pick_src = nf_hazard_pkg::FWD_WB;
        end else begin
            pick_src = nf_hazard_pkg::FWD_NONE;     // register file is current
        end
    endfunction : pick_src

    // exe operands have both mem and wb paths
    assign rd1_fwd_iexe = pick_src(writer_hit(ra1_iexe, wa3_imem, we_rf_imem),
                                   writer_hit(ra1_iexe, wa3_iwb,  we_rf_iwb ));
    assign rd2_fwd_iexe = pick_src(writer_hit(ra2_iexe, wa3_imem, we_rf_imem),
                                   writer_hit(ra2_iexe, wa3_iwb,  we_rf_iwb ));

    // branch comparator in id only gets the mem result
    // wb value reaches id through the rf write-through
    assign cmp1_fwd_id  = pick_src(writer_hit(ra1_id, wa3_imem, we_rf_imem), 1'b0);
    assign cmp2_fwd_id  = pick_src(writer_hit(ra2_id, wa3_imem, we_rf_imem), 1'b0);

endmodule : nf_hz_bypass_unit

/* hdl/nf_hz_stall_stats.sv */
`timescale 1ns/1ns

module nf_hz_stall_stats
#(
    parameter int CNT_W = 16                    // counter width
)(
    input   logic   [0 : 0]         clk,        // clock
    input   logic   [0 : 0]         rst_n,      // sync reset, active low
    input   logic   [0 : 0]         cnt_clr,    // sync clear of both counters
    input   logic   [0 : 0]         stall_if,   // fetch held this cycle
    input   logic   [0 : 0]         flush_iexe, // bubble injected into exe
    output  logic   [CNT_W-1 : 0]   stall_cnt,  // lost fetch cycles
    output  logic   [CNT_W-1 : 0]   flush_cnt   // exe bubbles
);

    logic   [CNT_W-1 : 0]   stall_nxt;          // next stall count
    logic   [CNT_W-1 : 0]   flush_nxt;          // next flush count

    // count up by one, stick at all ones
    function automatic logic [CNT_W-1 : 0] sat_inc(
        input   logic   [CNT_W-1 : 0]   cnt,    // current value
        input   logic   [0 : 0]         hit     // event seen this cycle
    );
        if (hit && !( & cnt )) begin
            sat_inc = cnt + CNT_W'(1);
        end else begin
            sat_inc = cnt;                      // idle or saturated
        end
    endfunction : sat_inc

    assign stall_nxt = sat_inc(stall_cnt, stall_if);
    assign flush_nxt = sat_inc(flush_cnt, flush_iexe);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_cnt <= '0;
            flush_cnt <= '0;
        end else if (cnt_clr) begin         // clear beats counting
            stall_cnt <= '0;
            flush_cnt <= '0;
        end else begin
            stall_cnt <= stall_nxt;
            flush_cnt <= flush_nxt;
        end
    end

endmodule : nf_hz_stall_stats

/* hdl/nf_hazard_unit.sv */
`timescale 1ns/1ns

module nf_hazard_unit
#(
    parameter int CNT_W = 16                                    // stats counter width
)(
    input   logic   [0 : 0]                     clk,            // clock
    input   logic   [0 : 0]                     rst_n,          // sync reset, active low
    input   logic   [0 : 0]                     cnt_clr,        // clear stats counters
    // id stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra1_id,        // read address 1
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra2_id,        // read address 2
    input   nf_hazard_pkg::branch_t             branch_type,    // branch kind
    // exe stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra1_iexe,      // read address 1
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] ra2_iexe,      // read address 2
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_iexe,      // write address
    input   logic   [0 : 0]                     we_rf_iexe,     // write enable
    input   logic   [0 : 0]                     rf_src_iexe,    // result comes from load
    // mem stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_imem,      // write address
    input   logic   [0 : 0]                     we_rf_imem,     // write enable
    input   logic   [0 : 0]                     rf_src_imem,    // result comes from load
    // wb stage
    input   logic   [nf_hazard_pkg::RF_AW-1 : 0] wa3_iwb,       // write address
    input   logic   [0 : 0]                     we_rf_iwb,      // write enable
    // memory side
    input   logic   [0 : 0]                     lsu_busy,       // data access pending
    input   logic   [0 : 0]                     lsu_err,        // data access fault
    input   logic   [0 : 0]                     req_ack_i,      // fetch acknowledged
    // stage control
    output  logic   [0 : 0]                     stall_if,
    output  logic   [0 : 0]                     stall_id,
    output  logic   [0 : 0]                     stall_iexe,
    output  logic   [0 : 0]                     stall_imem,
    output  logic   [0 : 0]                     stall_iwb,
    output  logic   [0 : 0]                     flush_id,
    output  logic   [0 : 0]                     flush_iexe,
    output  logic   [0 : 0]                     flush_imem,
    output  logic   [0 : 0]                     flush_iwb,
    // bypass selects
    output  nf_hazard_pkg::fwd_sel_t            rd1_fwd_iexe,   // exe operand 1
    output  nf_hazard_pkg::fwd_sel_t            rd2_fwd_iexe,   // exe operand 2
    output  nf_hazard_pkg::fwd_sel_t            cmp1_fwd_id,    // branch compare input 1
    output  nf_hazard_pkg::fwd_sel_t            cmp2_fwd_id,    // branch compare input 2
    // performance counters
    output  logic   [CNT_W-1 : 0]               stall_cnt,      // fetch stall cycles
    output  logic   [CNT_W-1 : 0]               flush_cnt       // exe flush cycles
);

    // stall and flush decisions
    nf_hz_stall_unit
    nf_hz_stall_unit_0
    (
        .we_rf_imem     ( we_rf_imem    ),      // shared with bypass
        .wa3_iexe       ( wa3_iexe      ),
        .wa3_imem       ( wa3_imem      ),      // shared with bypass
        .we_rf_iexe     ( we_rf_iexe    ),
        .rf_src_iexe    ( rf_src_iexe   ),
        .ra1_id         ( ra1_id        ),
        .ra2_id         ( ra2_id        ),
        .branch_type    ( branch_type   ),
        .lsu_busy       ( lsu_busy      ),
        .lsu_err        ( lsu_err       ),
        .req_ack_i      ( req_ack_i     ),
        .rf_src_imem    ( rf_src_imem   ),
        .stall_if       ( stall_if      ),
        .stall_id       ( stall_id      ),
        .stall_iexe     ( stall_iexe    ),
        .stall_imem     ( stall_imem    ),
        .stall_iwb      ( stall_iwb     ),
        .flush_id       ( flush_id      ),
        .flush_iexe     ( flush_iexe    ),
        .flush_imem     ( flush_imem    ),
        .flush_iwb      ( flush_iwb     )
    );

    // operand bypass for exe and id comparator
    nf_hz_bypass_unit
    nf_hz_bypass_unit_0
    (
        .ra1_iexe       ( ra1_iexe      ),
        .ra2_iexe       ( ra2_iexe      ),
        .ra1_id         ( ra1_id        ),
        .ra2_id         ( ra2_id        ),
        .wa3_imem       ( wa3_imem      ),
        .we_rf_imem     ( we_rf_imem    ),
        .wa3_iwb        ( wa3_iwb       ),
        .we_rf_iwb      ( we_rf_iwb     ),
        .rd1_fwd_iexe   ( rd1_fwd_iexe  ),
        .rd2_fwd_iexe   ( rd2_fwd_iexe  ),
        .cmp1_fwd_id    ( cmp1_fwd_id   ),
        .cmp2_fwd_id    ( cmp2_fwd_id   )
    );

    // bubble counters watch the decisions above
    nf_hz_stall_stats
    #(
        .CNT_W          ( CNT_W         )
    )
    nf_hz_stall_stats_0
    (
        .clk            ( clk           ),
        .rst_n          ( rst_n         ),
        .cnt_clr        ( cnt_clr       ),
        .stall_if       ( stall_if      ),      // front end hold
        .flush_iexe     ( flush_iexe    ),      // exe bubble
        .stall_cnt      ( stall_cnt     ),
        .flush_cnt      ( flush_cnt     )
    );

endmodule : nf_hazard_unit

/* test/nf_hazard_unit_checker.sv */
`timescale 1ns/1ns

module nf_hazard_unit_checker
#(
    parameter int CNT_W = 16                    // matches the bound unit
)(
    input   logic   [0 : 0]         clk,
    input   logic   [0 : 0]         rst_n,
    input   logic   [0 : 0]         cnt_clr,
    input   logic   [0 : 0]         stall_if,
    input   logic   [0 : 0]         stall_iexe,
    input   logic   [0 : 0]         flush_id,
    input   logic   [0 : 0]         flush_iexe,
    input   logic   [0 : 0]         flush_imem,
    input   logic   [0 : 0]         flush_iwb,
    input   logic   [CNT_W-1 : 0]   stall_cnt,
    input   logic   [CNT_W-1 : 0]   flush_cnt
);

    // back end only freezes on lsu, and that also holds the front end
    a_iexe_holds_front : assert property (@(posedge clk) stall_iexe |-> stall_if)
        else $error("stall_iexe high while stall_if low");

    // a fault flush always bubbles exe too
    a_flush_id_exe : assert property (@(posedge clk) flush_id |-> flush_iexe)
        else $error("flush_id high while flush_iexe low");

    a_flush_back_same : assert property (@(posedge clk)
        (flush_imem == flush_id) && (flush_iwb == flush_id))
        else $error("flush_imem or flush_iwb differs from flush_id");

    // first cycle out of reset and the cycle after a clear are exempt
    a_stall_cnt_up : assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(cnt_clr)) |-> (stall_cnt >= $past(stall_cnt)))
        else $error("stall_cnt went down without a clear");

    a_flush_cnt_up : assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(cnt_clr)) |-> (flush_cnt >= $past(flush_cnt)))
        else $error("flush_cnt went down without a clear");

endmodule : nf_hazard_unit_checker

bind nf_hazard_unit nf_hazard_unit_checker #(.CNT_W(CNT_W)) checker0 (
    .clk            ( clk           ),
    .rst_n          ( rst_n         ),
    .cnt_clr        ( cnt_clr       ),
    .stall_if       ( stall_if      ),
    .stall_iexe     ( stall_iexe    ),
    .flush_id       ( flush_id      ),
    .flush_iexe     ( flush_iexe    ),
    .flush_imem     ( flush_imem    ),
    .flush_iwb      ( flush_iwb     ),
    .stall_cnt      ( stall_cnt     ),
    .flush_cnt      ( flush_cnt     )
);

/* test/nf_hazard_unit_tb.sv */
`timescale 1ns/1ns

module nf_hazard_unit_tb;

    localparam int CNT_W       = 4;                 // small so saturation is reachable
    localparam int CNT_MAX     = (1 << CNT_W) - 1;
    localparam int CLK_PERIOD  = 10;
    localparam int N_BYPASS    = 200;               // random bypass sets
    localparam int WDOG_CYCLES = 10 * N_BYPASS;     // bypass sweep dominates, ~270 cycles total

    logic   [0 : 0]                         clk = 1'b0;
    logic   [0 : 0]                         rst_n;
    logic   [0 : 0]                         cnt_clr;
    logic   [nf_hazard_pkg::RF_AW-1 : 0]    ra1_id, ra2_id, ra1_iexe, ra2_iexe;
    logic   [nf_hazard_pkg::RF_AW-1 : 0]    wa3_iexe, wa3_imem, wa3_iwb;
    logic   [0 : 0]                         we_rf_iexe, rf_src_iexe, we_rf_imem, rf_src_imem;
    logic   [0 : 0]                         we_rf_iwb, lsu_busy, lsu_err, req_ack_i;
    nf_hazard_pkg::branch_t                 branch_type;
    logic   [0 : 0]                         stall_if, stall_id, stall_iexe, stall_imem;
    logic   [0 : 0]                         stall_iwb, flush_id, flush_iexe, flush_imem;
    logic   [0 : 0]                         flush_iwb;
    nf_hazard_pkg::fwd_sel_t                rd1_fwd_iexe, rd2_fwd_iexe;
    nf_hazard_pkg::fwd_sel_t                cmp1_fwd_id, cmp2_fwd_id;
    logic   [CNT_W-1 : 0]                   stall_cnt, flush_cnt;

    logic   [31 : 0]    lfsr_q = 32'ha47f_4857;     // random source state
    int                 exp_stall_n;                // counter model
    int                 exp_flush_n;
    string              cur_test = "reset";

    nf_hazard_unit #(.CNT_W(CNT_W)) dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31 : 0] lfsr_next(input logic [31 : 0] s);
        lfsr_next = {s[30 : 0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31 : 0] rand_bits(input int n);
        logic   [31 : 0]    v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);         // one step per bit
            v = {v[30 : 0], lfsr_q[0]};
        end
        rand_bits = v;
    endfunction

    // half the time a tiny pool, so matches and x0 show up often
    function automatic logic [nf_hazard_pkg::RF_AW-1 : 0] rand_addr();
        if (rand_bits(1) == 1) begin
            rand_addr = 5'(rand_bits(2));
        end else begin
            rand_addr = 5'(rand_bits(5));
        end
    endfunction

    // reference rules for the hazard conditions
    function automatic logic exp_load_use();
        exp_load_use = (ra1_id == wa3_iexe || ra2_id == wa3_iexe ||
                        ra1_id == wa3_imem || ra2_id == wa3_imem) &&
                       (we_rf_iexe || we_rf_imem) && (rf_src_iexe || rf_src_imem);
    endfunction

    function automatic logic exp_branch_hz();
        exp_branch_hz = branch_type != nf_hazard_pkg::B_NONE && we_rf_iexe &&
                        (wa3_iexe == ra1_id || wa3_iexe == ra2_id) &&
                        (ra1_id != 0 || ra2_id != 0);
    endfunction

    function automatic nf_hazard_pkg::fwd_sel_t exp_fwd(
        input   logic   [nf_hazard_pkg::RF_AW-1 : 0]    ra,
        input   logic                                   has_wb  // id comparator has no wb path
    );
        if (ra != 0 && we_rf_imem && wa3_imem == ra) begin
            exp_fwd = nf_hazard_pkg::FWD_MEM;
        end else if (has_wb && ra != 0 && we_rf_iwb && wa3_iwb == ra) begin
            exp_fwd = nf_hazard_pkg::FWD_WB;
        end else begin
            exp_fwd = nf_hazard_pkg::FWD_NONE;
        end
    endfunction

    task automatic fail_now(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [31 : 0] got,
                             input logic [31 : 0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("%s: %s is %0d, expected %0d", cur_test, what, got, exp));
        end
    endtask

    // every stall and flush against the reference rules
    task automatic check_ctrl();
        logic   front;
        logic   fx;
        front = exp_load_use() || exp_branch_hz() || !req_ack_i || lsu_busy;
        fx    = exp_load_use() || exp_branch_hz() || !req_ack_i || lsu_err;
        check_val("stall_if ref", stall_if, front);
        check_val("stall_id ref", stall_id, front);
        check_val("stall_iexe ref", stall_iexe, lsu_busy);
        check_val("stall_imem ref", stall_imem, lsu_busy);
        check_val("stall_iwb ref", stall_iwb, lsu_busy);
        check_val("flush_iexe ref", flush_iexe, fx);
        check_val("flush_id ref", flush_id, lsu_err);
        check_val("flush_imem ref", flush_imem, lsu_err);
        check_val("flush_iwb ref", flush_iwb, lsu_err);
    endtask

    // literal outcome of a directed case, then the reference check
    task automatic expect_ctrl(input logic front, input logic back, input logic fx,
                               input logic fall);
        check_val("stall_if", stall_if, front);
        check_val("stall_id", stall_id, front);
        check_val("stall_iexe", stall_iexe, back);
        check_val("stall_imem", stall_imem, back);
        check_val("stall_iwb", stall_iwb, back);
        check_val("flush_iexe", flush_iexe, fx);
        check_val("flush_id", flush_id, fall);
        check_val("flush_imem", flush_imem, fall);
        check_val("flush_iwb", flush_iwb, fall);
        check_ctrl();
    endtask

    task automatic check_bypass();
        check_val("rd1_fwd_iexe", rd1_fwd_iexe, exp_fwd(ra1_iexe, 1'b1));
        check_val("rd2_fwd_iexe", rd2_fwd_iexe, exp_fwd(ra2_iexe, 1'b1));
        check_val("cmp1_fwd_id", cmp1_fwd_id, exp_fwd(ra1_id, 1'b0));
        check_val("cmp2_fwd_id", cmp2_fwd_id, exp_fwd(ra2_id, 1'b0));
    endtask

    task automatic check_counts();
        check_val("stall_cnt", stall_cnt, exp_stall_n);
        check_val("flush_cnt", flush_cnt, exp_flush_n);
    endtask

    // quiet pipe, all addresses distinct so nothing collides
    task automatic drive_idle();
        cnt_clr     <= 1'b0;
        ra1_id      <= 5'd1;
        ra2_id      <= 5'd2;
        branch_type <= nf_hazard_pkg::B_NONE;
        ra1_iexe    <= 5'd3;
        ra2_iexe    <= 5'd4;
        wa3_iexe    <= 5'd5;
        we_rf_iexe  <= 1'b0;
        rf_src_iexe <= 1'b0;
        wa3_imem    <= 5'd6;
        we_rf_imem  <= 1'b0;
        rf_src_imem <= 1'b0;
        wa3_iwb     <= 5'd7;
        we_rf_iwb   <= 1'b0;
        lsu_busy    <= 1'b0;
        lsu_err     <= 1'b0;
        req_ack_i   <= 1'b1;                    // fetch always acked
    endtask

    task automatic load_case(input logic [4 : 0] wa, input logic we, input logic src,
                             input logic hz);
        @(posedge clk);
        drive_idle();
        ra1_id      <= 5'd9;
        wa3_iexe    <= wa;
        we_rf_iexe  <= we;
        rf_src_iexe <= src;
        @(negedge clk);
        expect_ctrl(hz, 1'b0, hz, 1'b0);
    endtask

    task automatic test_load_use();
        cur_test = "load-use";
        load_case(5'd9, 1'b1, 1'b1, 1'b1);      // full hazard
        load_case(5'd10, 1'b1, 1'b1, 1'b0);     // no address match
        load_case(5'd9, 1'b0, 1'b1, 1'b0);      // no write enable
        load_case(5'd9, 1'b1, 1'b0, 1'b0);      // alu result, not a load
        @(posedge clk);
        drive_idle();
        ra2_id      <= 5'd6;                    // hits idle wa3_imem
        we_rf_imem  <= 1'b1;
        rf_src_imem <= 1'b1;
        @(negedge clk);
        expect_ctrl(1'b1, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic branch_case(input int kind, input logic [4 : 0] ra1, input logic [4 : 0] ra2,
                               input logic [4 : 0] wa, input logic hz);
        @(posedge clk);
        drive_idle();
        branch_type <= nf_hazard_pkg::branch_t'(kind);
        ra1_id      <= ra1;
        ra2_id      <= ra2;
        wa3_iexe    <= wa;
        we_rf_iexe  <= 1'b1;                    // exe writes, but not from a load
        @(negedge clk);
        expect_ctrl(hz, 1'b0, hz, 1'b0);
    endtask

    task automatic test_branch();
        cur_test = "branch";
        for (int k = 1; k <= 5; k++) begin
            branch_case(k, 5'd12, 5'd2, 5'd12, 1'b1);
        end
        branch_case(1, 5'd1, 5'd13, 5'd13, 1'b1);   // match on operand 2
        branch_case(1, 5'd0, 5'd0, 5'd0, 1'b0);     // x0 operands only
        branch_case(0, 5'd12, 5'd2, 5'd12, 1'b0);   // not a branch
    endtask

    task automatic test_mem_cond();
        cur_test = "memory conditions";
        @(posedge clk);
        drive_idle();
        lsu_busy <= 1'b1;
        @(negedge clk);
        expect_ctrl(1'b1, 1'b1, 1'b0, 1'b0);    // whole pipe frozen
        @(posedge clk);
        drive_idle();
        lsu_err <= 1'b1;
        @(negedge clk);
        expect_ctrl(1'b0, 1'b0, 1'b1, 1'b1);
        @(posedge clk);
        drive_idle();
        req_ack_i <= 1'b0;
        @(negedge clk);
        expect_ctrl(1'b1, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic test_bypass();
        cur_test = "bypass priority";
        @(posedge clk);
        drive_idle();
        ra1_iexe   <= 5'd8;
        ra1_id     <= 5'd8;
        ra2_iexe   <= 5'd0;
        wa3_imem   <= 5'd8;
        wa3_iwb    <= 5'd8;
        we_rf_imem <= 1'b1;
        we_rf_iwb  <= 1'b1;
        @(negedge clk);
        check_val("rd1_fwd_iexe", rd1_fwd_iexe, nf_hazard_pkg::FWD_MEM);  // mem beats wb
        check_bypass();
        @(posedge clk);
        wa3_imem <= 5'd0;                       // write to x0 is not forwarded
        wa3_iwb  <= 5'd0;
        @(negedge clk);
        check_val("rd2_fwd_iexe", rd2_fwd_iexe, nf_hazard_pkg::FWD_NONE);
        check_bypass();
        cur_test = "bypass random";
        for (int n = 0; n < N_BYPASS; n++) begin
            @(posedge clk);
            drive_idle();
            ra1_iexe   <= rand_addr();
            ra2_iexe   <= rand_addr();
            ra1_id     <= rand_addr();
            ra2_id     <= rand_addr();
            wa3_imem   <= rand_addr();
            wa3_iwb    <= rand_addr();
            we_rf_imem <= rand_bits(1) == 1;
            we_rf_iwb  <= rand_bits(1) == 1;
            @(negedge clk);
            check_bypass();
            check_ctrl();
        end
    endtask

    // hold one condition for n cycles, checking counts every cycle
    task automatic hold_cycles(input logic busy, input logic err, input logic ack, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            drive_idle();
            lsu_busy  <= busy;
            lsu_err   <= err;
            req_ack_i <= ack;
            @(negedge clk);
            check_ctrl();
            check_counts();
            if ((busy || !ack) && exp_stall_n < CNT_MAX) exp_stall_n++;
            if ((err || !ack) && exp_flush_n < CNT_MAX) exp_flush_n++;
        end
    endtask

    task automatic test_counters();
        cur_test = "counters";
        @(posedge clk);
        drive_idle();
        cnt_clr <= 1'b1;
        @(posedge clk);
        cnt_clr <= 1'b0;
        @(negedge clk);
        exp_stall_n = 0;
        exp_flush_n = 0;
        check_counts();
        hold_cycles(1'b1, 1'b0, 1'b1, 5);       // stalls only
        hold_cycles(1'b0, 1'b1, 1'b1, 3);       // flushes only
        hold_cycles(1'b0, 1'b0, 1'b1, 2);
        check_val("stall_cnt", stall_cnt, 5);
        check_val("flush_cnt", flush_cnt, 3);
        hold_cycles(1'b0, 1'b0, 1'b0, 20);      // both run into saturation
        hold_cycles(1'b0, 1'b0, 1'b1, 2);
        check_val("stall_cnt", stall_cnt, CNT_MAX);
        check_val("flush_cnt", flush_cnt, CNT_MAX);
        @(posedge clk);
        drive_idle();
        req_ack_i <= 1'b0;                      // clear must win over counting
        cnt_clr   <= 1'b1;
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_val("stall_cnt", stall_cnt, 0);
        check_val("flush_cnt", flush_cnt, 0);
    endtask

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("error: simulation timed out before the tests finished");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n <= 1'b0;
        drive_idle();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        exp_stall_n = 0;
        exp_flush_n = 0;
        check_counts();                         // reset leaves zeros
        check_ctrl();
        test_load_use();
        test_branch();
        test_mem_cond();
        test_bypass();
        test_counters();
        $display("Testbench passed");
        $finish;
    end

endmodule : nf_hazard_unit_tb

/* vlog.f */
hdl/nf_hazard_pkg.sv
hdl/nf_hz_stall_unit.sv
hdl/nf_hz_bypass_unit.sv
hdl/nf_hz_stall_stats.sv
hdl/nf_hazard_unit.sv
test/nf_hazard_unit_checker.sv
test/nf_hazard_unit_tb.sv

/* Bender.yml */
package:
  name: nf_hazard_unit

sources:
  - files:
      - hdl/nf_hazard_pkg.sv
      - hdl/nf_hz_stall_unit.sv
      - hdl/nf_hz_bypass_unit.sv
      - hdl/nf_hz_stall_stats.sv
      - hdl/nf_hazard_unit.sv
  - target: test
    files:
      - test/nf_hazard_unit_checker.sv
      - test/nf_hazard_unit_tb.sv
